// ==== rv_decode.f ====
+incdir+testbench
hdl/rv_pkg.sv
hdl/regfile.sv
hdl/imm_gen.sv
hdl/ctrl_unit.sv
hdl/csr_regs.sv
hdl/id_stage.sv
testbench/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_id_stage with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_id_stage \
	-f rv_decode.f -o tb_id_stage
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_id_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation ended with an error status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// ==== testbench/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// one cycle of stimulus for the decode stage
typedef struct packed {
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] pc4;
	logic        hit;
	wb_t         wb;
	csr_wr_t     csr_wr;
	logic        en;
	logic        flush;
	logic        intr;
} stim_t;

logic [31:0] m_regs [32];
logic        m_mie;
logic        m_mpie;
logic        m_meie;
logic [31:0] m_mtvec;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic        m_intr_q;
logic [31:0] m_pc_intr_q;
id_ex_t      exp_id_ex;

function automatic imm_sel_e model_imm_sel(input logic [31:0] i);
	case (i[6:0])
		OP_LUI, OP_AUIPC: return IMM_U;
		OP_JAL:           return IMM_J;
		OP_BRANCH:        return IMM_B;
		OP_STORE:         return IMM_S;
		default:          return IMM_I;
	endcase
endfunction

// immediates in the usual RV32I bit order
function automatic logic [31:0] model_imm(input logic [31:0] i, input imm_sel_e sel);
	case (sel)
		IMM_S:   return {{20{i[31]}}, i[31:25], i[11:7]};
		IMM_B:   return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
		IMM_U:   return {i[31:12], 12'd0};
		IMM_J:   return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
		default: return {{20{i[31]}}, i[31:20]};
	endcase
endfunction

function automatic alu_op_e model_alu(input logic [2:0] f3, input logic alt);
	case (f3)
		3'b000:  return alt ? ALU_SUB : ALU_ADD;
		3'b001:  return ALU_SLL;
		3'b010:  return ALU_SLT;
		3'b011:  return ALU_SLTU;
		3'b100:  return ALU_XOR;
		3'b101:  return alt ? ALU_SRA : ALU_SRL;
		3'b110:  return ALU_OR;
		default: return ALU_AND;
	endcase
endfunction

function automatic ctrl_t model_ctrl(input logic [31:0] i);
	ctrl_t      c;
	logic [2:0] f3;
	c  = '0;
	f3 = i[14:12];
	case (i[6:0])
		OP_LUI: begin
			c.alu_sel = ALU_PASS_B;
			c.b_sel   = 1'b1;
			c.wb_sel  = WB_ALU;
			c.reg_wen = 1'b1;
		end
		OP_AUIPC: begin
			c.a_sel   = 1'b1;
			c.b_sel   = 1'b1;
			c.wb_sel  = WB_ALU;
			c.reg_wen = 1'b1;
		end
		OP_JAL: begin
			c.a_sel   = 1'b1;
			c.b_sel   = 1'b1;
			c.wb_sel  = WB_PC4;
			c.reg_wen = 1'b1;
		end
		OP_JALR: begin
			c.b_sel   = 1'b1;
			c.wb_sel  = WB_PC4;
			c.reg_wen = 1'b1;
		end
		OP_BRANCH: begin
			c.a_sel = 1'b1;
			c.b_sel = 1'b1;
			c.br_un = (f3 == 3'b110) || (f3 == 3'b111); // bltu, bgeu
		end
		OP_LOAD: begin
			c.b_sel     = 1'b1;
			c.mem_valid = 1'b1;
			c.wb_sel    = WB_MEM;
			c.reg_wen   = 1'b1;
		end
		OP_STORE: begin
			c.b_sel     = 1'b1;
			c.mem_rw    = 1'b1;
			c.mem_valid = 1'b1;
		end
		OP_IMM: begin
			c.alu_sel = model_alu(f3, i[30] && (f3 == 3'b101)); // only srai
			c.b_sel   = 1'b1;
			c.wb_sel  = WB_ALU;
			c.reg_wen = 1'b1;
		end
		OP_OP: begin
			c.alu_sel = model_alu(f3, i[30]);
			c.wb_sel  = WB_ALU;
			c.reg_wen = 1'b1;
		end
		OP_SYSTEM: begin
			if (f3 == 3'b001 || f3 == 3'b010 || f3 == 3'b011) begin
				c.alu_sel = (f3 == 3'b001) ? ALU_PASS_B : (f3 == 3'b010) ? ALU_OR : ALU_ANDN;
				c.wb_sel  = WB_CSR;
				c.reg_wen = 1'b1;
				c.csr_we  = 1'b1;
			end
		end
		default: c = '0;
	endcase
	return c;
endfunction

function automatic logic [31:0] model_reg_read(input logic [4:0] a, input wb_t wb);
	if (a == 5'd0) return 32'd0;
	if (wb.wen && wb.rd == a) return wb.data; // value landing this cycle
	return m_regs[a];
endfunction

function automatic logic [31:0] model_csr_read(input logic [11:0] a);
	case (a)
		CSR_MSTATUS: return {24'd0, m_mpie, 3'd0, m_mie, 3'd0};
		CSR_MIE:     return {20'd0, m_meie, 11'd0};
		CSR_MTVEC:   return m_mtvec;
		CSR_MEPC:    return m_mepc;
		CSR_MCAUSE:  return m_mcause;
		default:     return 32'd0;
	endcase
endfunction

task automatic model_reset();
	for (int k = 0; k < 32; k++) begin
		m_regs[k] = 32'd0;
	end
	m_mie       = 1'b0;
	m_mpie      = 1'b0;
	m_meie      = 1'b0;
	m_mtvec     = TRAP_VEC;
	m_mepc      = 32'd0;
	m_mcause    = 32'd0;
	m_intr_q    = 1'b0;
	m_pc_intr_q = 32'd0;
	exp_id_ex   = '0;
endtask

// everything the next rising edge does, given the inputs in front of it
task automatic model_step(input stim_t s);
	id_ex_t d;
	logic   trap;
	d           = '0;
	d.ctrl      = model_ctrl(s.inst);
	d.rs1_data  = model_reg_read(s.inst[19:15], s.wb);
	d.rs2_data  = model_reg_read(s.inst[24:20], s.wb);
	d.imm       = model_imm(s.inst, model_imm_sel(s.inst));
	d.pc        = s.pc;
	d.pc4       = s.pc4;
	d.inst      = s.inst;
	d.rd        = s.inst[11:7];
	d.hit       = s.hit;
	d.csr_rdata = model_csr_read(s.inst[31:20]);
	d.csr_waddr = s.inst[31:20];
	d.is_mret   = (s.inst == INST_MRET);
	d.pc_mret   = m_mepc;
	if (s.en) begin
		exp_id_ex = s.flush ? id_ex_t'('0) : d;
	end
	trap = s.intr && m_mie && m_meie;
	if (s.en || !m_intr_q) begin // pending trap kept through a stall
		m_intr_q    = trap;
		m_pc_intr_q = m_mtvec;
	end
	if (s.wb.wen && s.wb.rd != 5'd0) begin
		m_regs[s.wb.rd] = s.wb.data;
	end
	if (trap) begin
		m_mepc   = s.pc;
		m_mcause = MCAUSE_EXT_INTR;
		m_mpie   = m_mie;
		m_mie    = 1'b0;
	end else if (d.is_mret && !s.flush) begin
		m_mie  = m_mpie;
		m_mpie = 1'b1;
	end
	if (s.csr_wr.we) begin // port wins over entry and return
		case (s.csr_wr.addr)
			CSR_MSTATUS: begin
				m_mie  = s.csr_wr.data[3];
				m_mpie = s.csr_wr.data[7];
			end
			CSR_MIE:    m_meie   = s.csr_wr.data[11];
			CSR_MTVEC:  m_mtvec  = s.csr_wr.data;
			CSR_MEPC:   m_mepc   = s.csr_wr.data;
			CSR_MCAUSE: m_mcause = s.csr_wr.data;
			default: ;
		endcase
	end
endtask

`endif

// ==== testbench/tb_id_stage.sv ====
module tb_id_stage;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_pkg::*;

	localparam logic [31:0] TRAP_VEC = 32'h0000_0100;
	localparam logic [31:0] SEED     = 32'hce69_4a71;
	localparam int N_REG   = 200;
	localparam int N_DEC   = 300;
	localparam int N_STALL = 120;
	localparam int N_CSR   = 150;
	localparam int N_INTR  = 8;
	localparam int TOTAL_CYCLES = 5 + N_REG + N_DEC + N_STALL + N_CSR + N_INTR + 2;
	localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES + 100;

	`include "id_model.svh"

	logic        clk_i = 1'b0;
	logic        rst_ni;
	logic [31:0] inst_d;
	logic [31:0] pc_d;
	logic [31:0] pc4_d;
	logic        hit_d;
	wb_t         wb;
	csr_wr_t     csr_wr;
	logic        enable;
	logic        flush;
	logic        e_intr;
	id_ex_t      id_ex;
	logic        intr;
	logic [31:0] pc_intr;
	int          cycle_cnt = 0;

	id_stage #(
		.TRAP_VEC (TRAP_VEC)
	) u_id_stage (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.inst_d_i  (inst_d),
		.pc_d_i    (pc_d),
		.pc4_d_i   (pc4_d),
		.hit_d_i   (hit_d),
		.wb_i      (wb),
		.csr_wr_i  (csr_wr),
		.enable_i  (enable),
		.flush_i   (flush),
		.e_intr_i  (e_intr),
		.id_ex_o   (id_ex),
		.intr_o    (intr),
		.pc_intr_o (pc_intr)
	);

	always #10 clk_i = ~clk_i;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			stop_on_error("timeout: the run went past its cycle limit");
		end
	end

	task automatic report_mismatch(input string field, input logic [31:0] got,
	                               input logic [31:0] exp);
		stop_on_error($sformatf("Fail at %0t ns: %s got %08h expected %08h",
		                        $time, field, got, exp));
	endtask

	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp);
		if (got.ctrl !== exp.ctrl)
			report_mismatch("ctrl", 32'(got.ctrl), 32'(exp.ctrl));
		else if (got.rs1_data !== exp.rs1_data)
			report_mismatch("rs1_data", got.rs1_data, exp.rs1_data);
		else if (got.rs2_data !== exp.rs2_data)
			report_mismatch("rs2_data", got.rs2_data, exp.rs2_data);
		else if (got.imm !== exp.imm)
			report_mismatch("imm", got.imm, exp.imm);
		else if (got.pc !== exp.pc)
			report_mismatch("pc", got.pc, exp.pc);
		else if (got.pc4 !== exp.pc4)
			report_mismatch("pc4", got.pc4, exp.pc4);
		else if (got.inst !== exp.inst)
			report_mismatch("inst", got.inst, exp.inst);
		else if (got.rd !== exp.rd)
			report_mismatch("rd", 32'(got.rd), 32'(exp.rd));
		else if (got.hit !== exp.hit)
			report_mismatch("hit", 32'(got.hit), 32'(exp.hit));
		else if (got.csr_rdata !== exp.csr_rdata)
			report_mismatch("csr_rdata", got.csr_rdata, exp.csr_rdata);
		else if (got.csr_waddr !== exp.csr_waddr)
			report_mismatch("csr_waddr", 32'(got.csr_waddr), 32'(exp.csr_waddr));
		else if (got.is_mret !== exp.is_mret)
			report_mismatch("is_mret", 32'(got.is_mret), 32'(exp.is_mret));
		else if (got.pc_mret !== exp.pc_mret)
			report_mismatch("pc_mret", got.pc_mret, exp.pc_mret);
	endtask

	task automatic check_trap(input logic got_flag, input logic [31:0] got_pc,
	                          input logic exp_flag, input logic [31:0] exp_pc);
		if (got_flag !== exp_flag) report_mismatch("intr_o", 32'(got_flag), 32'(exp_flag));
		else if (got_pc !== exp_pc) report_mismatch("pc_intr_o", got_pc, exp_pc);
	endtask

	function automatic stim_t idle_stim();
		stim_t s;
		s    = '0;
		s.en = 1'b1;
		return s;
	endfunction

	function automatic wb_t random_wb();
		wb_t         w;
		logic [31:0] r;
		r      = $urandom;
		w.wen  = r[0] | r[1]; // three writes in four
		w.rd   = r[6:2];
		w.data = $urandom;
		return w;
	endfunction

	function automatic stim_t random_stim(input logic [31:0] inst);
		stim_t       s;
		logic [31:0] r;
		r      = $urandom;
		s      = idle_stim();
		s.inst = inst;
		s.pc   = {r[31:2], 2'b00};
		s.pc4  = {r[31:2], 2'b00} + 32'd4;
		s.hit  = r[0];
		s.wb   = random_wb();
		return s;
	endfunction

	function automatic logic is_known_opcode(input logic [6:0] op);
		return op inside {OP_LOAD, OP_IMM, OP_AUIPC, OP_STORE, OP_OP,
		                  OP_LUI, OP_BRANCH, OP_JALR, OP_JAL, OP_SYSTEM};
	endfunction

	function automatic logic [31:0] random_inst();
		logic [31:0] r;
		logic [6:0]  op;
		r = $urandom;
		case ($urandom_range(0, 10))
			0: op = OP_LUI;
			1: op = OP_AUIPC;
			2: op = OP_JAL;
			3: op = OP_JALR;
			4: op = OP_BRANCH;
			5: op = OP_LOAD;
			6: op = OP_STORE;
			7: op = OP_IMM;
			8: op = OP_OP;
			9: op = OP_SYSTEM;
			default: begin
				op = r[6:0];
				while (is_known_opcode(op)) op = op + 7'd1;
			end
		endcase
		if (op == OP_SYSTEM && $urandom_range(0, 7) == 0) return INST_MRET;
		return {r[31:7], op};
	endfunction

	function automatic logic [11:0] random_csr_addr();
		logic [31:0] r;
		r = $urandom;
		case ($urandom_range(0, 5))
			0:       return CSR_MSTATUS;
			1:       return CSR_MIE;
			2:       return CSR_MTVEC;
			3:       return CSR_MEPC;
			4:       return CSR_MCAUSE;
			default: return r[11:0];
		endcase
	endfunction

	// drive at the rising edge, check the previous edge's result at the falling edge
	task automatic run_cycle(input stim_t s);
		@(posedge clk_i);
		inst_d <= s.inst;
		pc_d   <= s.pc;
		pc4_d  <= s.pc4;
		hit_d  <= s.hit;
		wb     <= s.wb;
		csr_wr <= s.csr_wr;
		enable <= s.en;
		flush  <= s.flush;
		e_intr <= s.intr;
		@(negedge clk_i);
		check_id_ex(id_ex, exp_id_ex);
		check_trap(intr, pc_intr, s.en ? m_intr_q : 1'b0, s.en ? m_pc_intr_q : 32'd0);
		model_step(s);
	endtask

	initial begin
		stim_t       s;
		logic [31:0] r;
		logic [31:0] trap_pc_val;
		void'($urandom(SEED));
		rst_ni = 1'b0;
		inst_d = '0;
		pc_d   = '0;
		pc4_d  = '0;
		hit_d  = 1'b0;
		wb     = '0;
		csr_wr = '0;
		enable = 1'b1;
		flush  = 1'b0;
		e_intr = 1'b0;
		repeat (5) @(posedge clk_i);
		rst_ni <= 1'b1;
		model_reset();
		model_step(idle_stim()); // first edge out of reset sees the idle inputs

		for (int i = 0; i < N_REG; i++) begin // register reads
			r = $urandom;
			s = random_stim({r[30] ? 7'h20 : 7'h00, r[24:7], OP_OP});
			if (r[0] && r[1]) s.inst[19:15] = s.wb.rd;
			if (r[2] && r[3]) s.inst[24:20] = s.wb.rd;
			if (r[4] && r[5] && r[6]) s.inst[24:20] = 5'd0;
			run_cycle(s);
		end
		for (int i = 0; i < N_DEC; i++) begin // immediates and controls
			run_cycle(random_stim(random_inst()));
		end
		for (int i = 0; i < N_STALL; i++) begin // stall and flush
			s       = random_stim(random_inst());
			s.en    = ($urandom_range(0, 2) != 0);
			s.flush = ($urandom_range(0, 4) == 0);
			run_cycle(s);
		end
		for (int i = 0; i < N_CSR; i++) begin // csr port and csrrs reads
			r = $urandom;
			s = random_stim({random_csr_addr(), r[19:15], 3'b010, r[11:7], OP_SYSTEM});
			s.csr_wr.we   = r[0];
			s.csr_wr.addr = random_csr_addr();
			s.csr_wr.data = $urandom;
			run_cycle(s);
		end

		s = idle_stim(); // interrupt entry and mret
		s.csr_wr.we   = 1'b1;
		s.csr_wr.addr = CSR_MSTATUS;
		s.csr_wr.data = 32'h0000_0008;
		run_cycle(s);
		s.csr_wr.addr = CSR_MIE;
		s.csr_wr.data = 32'h0000_0800;
		run_cycle(s);
		r           = $urandom;
		trap_pc_val = {r[31:2], 2'b00};
		s           = idle_stim();
		s.inst      = 32'h0000_0013;
		s.pc        = trap_pc_val;
		s.pc4       = trap_pc_val + 32'd4;
		s.intr      = 1'b1;
		run_cycle(s);
		s      = idle_stim();
		s.inst = {CSR_MEPC, 5'd0, 3'b010, 5'd1, OP_SYSTEM};
		run_cycle(s);
		check_trap(intr, pc_intr, 1'b1, m_mtvec); // taken one edge after e_intr_i
		s.inst = INST_MRET;
		run_cycle(s);
		if (id_ex.csr_rdata !== trap_pc_val) begin // csrrs of mepc
			report_mismatch("mepc", id_ex.csr_rdata, trap_pc_val);
		end
		s.inst = {CSR_MSTATUS, 5'd0, 3'b010, 5'd2, OP_SYSTEM};
		run_cycle(s);
		if (id_ex.is_mret !== 1'b1) begin
			report_mismatch("is_mret", 32'(id_ex.is_mret), 32'd1);
		end else if (id_ex.pc_mret !== trap_pc_val) begin
			report_mismatch("pc_mret", id_ex.pc_mret, trap_pc_val);
		end
		run_cycle(idle_stim());
		if (id_ex.csr_rdata[MSTATUS_MIE] !== 1'b1) begin // csrrs of mstatus after mret
			report_mismatch("mstatus.MIE", 32'(id_ex.csr_rdata[MSTATUS_MIE]), 32'd1);
		end
		run_cycle(idle_stim());

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== hdl/id_stage.sv ====
module id_stage #(
	parameter logic [31:0] TRAP_VEC = 32'h0000_0100
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic [31:0]     inst_d_i,
	input  logic [31:0]     pc_d_i,
	input  logic [31:0]     pc4_d_i,
	input  logic            hit_d_i,
	input  rv_pkg::wb_t     wb_i,
	input  rv_pkg::csr_wr_t csr_wr_i,
	input  logic            enable_i, // low = stall
	input  logic            flush_i,
	input  logic            e_intr_i,
	output rv_pkg::id_ex_t  id_ex_o,
	output logic            intr_o,
	output logic [31:0]     pc_intr_o
);
	import rv_pkg::*;

	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] imm;
	ctrl_t       ctrl;
	imm_sel_e    imm_sel;
	logic        is_mret;
	logic        csr_mret;
	logic [31:0] csr_rdata;
	logic        trap;
	logic [31:0] trap_pc;
	logic [31:0] mepc;
	id_ex_t      id_ex_d;
	id_ex_t      id_ex_q;
	logic        intr_q;
	logic [31:0] pc_intr_q;

	regfile u_regfile (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.wb_i       (wb_i),
		.rs1_addr_i (inst_d_i[19:15]),
		.rs2_addr_i (inst_d_i[24:20]),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	imm_gen u_imm_gen (
		.inst_i    (inst_d_i[31:7]),
		.imm_sel_i (imm_sel),
		.imm_o     (imm)
	);

	ctrl_unit u_ctrl_unit (
		.inst_i    (inst_d_i),
		.ctrl_o    (ctrl),
		.imm_sel_o (imm_sel),
		.is_mret_o (is_mret)
	);

	assign csr_mret = is_mret && !flush_i; // flushed mret must not touch mstatus

	csr_regs #(
		.TRAP_VEC (TRAP_VEC)
	) u_csr_regs (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.e_intr_i  (e_intr_i),
		.is_mret_i (csr_mret),
		.raddr_i   (inst_d_i[31:20]),
		.pc_i      (pc_d_i),
		.wr_i      (csr_wr_i),
		.rdata_o   (csr_rdata),
		.trap_o    (trap),
		.trap_pc_o (trap_pc),
		.mepc_o    (mepc)
	);

	always_comb begin
		id_ex_d.ctrl      = ctrl;
		id_ex_d.rs1_data  = rs1_data;
		id_ex_d.rs2_data  = rs2_data;
		id_ex_d.imm       = imm;
		id_ex_d.pc        = pc_d_i;
		id_ex_d.pc4       = pc4_d_i;
		id_ex_d.inst      = inst_d_i;
		id_ex_d.rd        = inst_d_i[11:7];
		id_ex_d.hit       = hit_d_i;
		id_ex_d.csr_rdata = csr_rdata;
		id_ex_d.csr_waddr = inst_d_i[31:20];
		id_ex_d.is_mret   = is_mret;
		id_ex_d.pc_mret   = mepc; // return target as read now
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			id_ex_q <= '0;
		end else if (enable_i) begin
			id_ex_q <= flush_i ? '0 : id_ex_d; // flush inserts a bubble
		end
	end

	// a pending trap is kept through a stall so it is not lost
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			intr_q    <= 1'b0;
			pc_intr_q <= '0;
		end else if (!enable_i && intr_q) begin
			intr_q    <= intr_q;
			pc_intr_q <= pc_intr_q;
		end else begin
			intr_q    <= trap;
			pc_intr_q <= trap_pc;
		end
	end

	assign id_ex_o   = id_ex_q;
	assign intr_o    = enable_i ? intr_q : 1'b0;
	assign pc_intr_o = enable_i ? pc_intr_q : 32'd0;

endmodule

// ==== hdl/csr_regs.sv ====
module csr_regs #(
	parameter logic [31:0] TRAP_VEC = 32'h0000_0100
) (
	input  logic            clk_i,
	input  logic            rst_ni,
	input  logic            e_intr_i,
	input  logic            is_mret_i,
	input  logic [11:0]     raddr_i,
	input  logic [31:0]     pc_i,
	input  rv_pkg::csr_wr_t wr_i,
	output logic [31:0]     rdata_o,
	output logic            trap_o,
	output logic [31:0]     trap_pc_o,
	output logic [31:0]     mepc_o
);
	import rv_pkg::*;

	logic        mstatus_mie;
	logic        mstatus_mpie;
	logic        mie_meie;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;

	assign trap_o    = e_intr_i && mstatus_mie && mie_meie;
	assign trap_pc_o = mtvec;
	assign mepc_o    = mepc;

	always_comb begin
		rdata_o = '0; // unknown address reads zero
		case (raddr_i)
			CSR_MSTATUS: begin
				rdata_o[MSTATUS_MIE]  = mstatus_mie;
				rdata_o[MSTATUS_MPIE] = mstatus_mpie;
			end
			CSR_MIE:    rdata_o[MIE_MEIE] = mie_meie;
			CSR_MTVEC:  rdata_o = mtvec;
			CSR_MEPC:   rdata_o = mepc;
			CSR_MCAUSE: rdata_o = mcause;
			default:    rdata_o = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie     <= 1'b0;
			mtvec        <= TRAP_VEC;
			mepc         <= '0;
			mcause       <= '0;
		end else begin
			if (trap_o) begin // interrupt entry
				mepc         <= pc_i;
				mcause       <= MCAUSE_EXT_INTR;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie  <= 1'b0;
			end else if (is_mret_i) begin
				mstatus_mie  <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end
			// port write comes last and overrides entry / return on the same csr
			if (wr_i.we) begin
				case (wr_i.addr)
					CSR_MSTATUS: begin
						mstatus_mie  <= wr_i.data[MSTATUS_MIE];
						mstatus_mpie <= wr_i.data[MSTATUS_MPIE];
					end
					CSR_MIE:    mie_meie <= wr_i.data[MIE_MEIE];
					CSR_MTVEC:  mtvec    <= wr_i.data;
					CSR_MEPC:   mepc     <= wr_i.data;
					CSR_MCAUSE: mcause   <= wr_i.data;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hdl/ctrl_unit.sv ====
module ctrl_unit (
	input  logic [31:0]      inst_i,
	output rv_pkg::ctrl_t    ctrl_o,
	output rv_pkg::imm_sel_e imm_sel_o,
	output logic             is_mret_o
);
	import rv_pkg::*;

	logic [2:0] funct3;
	logic       alt;      // inst[30], sub / sra
	logic       imm_alt;  // only srai uses it in op-imm

	assign funct3  = inst_i[14:12];
	assign alt     = inst_i[30];
	assign imm_alt = alt && (funct3 == 3'b101);

	function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl_o    = '0;
		imm_sel_o = IMM_I;
		is_mret_o = 1'b0;
		case (inst_i[6:0])
			OP_LUI: begin
				ctrl_o.alu_sel = ALU_PASS_B;
				ctrl_o.b_sel   = 1'b1;
				ctrl_o.wb_sel  = WB_ALU;
				ctrl_o.reg_wen = 1'b1;
				imm_sel_o      = IMM_U;
			end
			OP_AUIPC: begin
				ctrl_o.a_sel   = 1'b1;
				ctrl_o.b_sel   = 1'b1;
				ctrl_o.wb_sel  = WB_ALU;
				ctrl_o.reg_wen = 1'b1;
				imm_sel_o      = IMM_U;
			end
			OP_JAL: begin
				ctrl_o.a_sel   = 1'b1;
				ctrl_o.b_sel   = 1'b1;
				ctrl_o.wb_sel  = WB_PC4;
				ctrl_o.reg_wen = 1'b1;
				imm_sel_o      = IMM_J;
			end
			OP_JALR: begin
				ctrl_o.b_sel   = 1'b1;
				ctrl_o.wb_sel  = WB_PC4;
				ctrl_o.reg_wen = 1'b1;
			end
			OP_BRANCH: begin
				ctrl_o.a_sel = 1'b1; // target = pc + imm
				ctrl_o.b_sel = 1'b1;
				ctrl_o.br_un = funct3[2] && funct3[1]; // bltu, bgeu
				imm_sel_o    = IMM_B;
			end
			OP_LOAD: begin
				ctrl_o.b_sel     = 1'b1;
				ctrl_o.mem_valid = 1'b1;
				ctrl_o.wb_sel    = WB_MEM;
				ctrl_o.reg_wen   = 1'b1;
			end
			OP_STORE: begin
				ctrl_o.b_sel     = 1'b1;
				ctrl_o.mem_rw    = 1'b1;
				ctrl_o.mem_valid = 1'b1;
				imm_sel_o        = IMM_S;
			end
			OP_IMM: begin
				ctrl_o.alu_sel = alu_dec(funct3, imm_alt);
				ctrl_o.b_sel   = 1'b1;
				ctrl_o.wb_sel  = WB_ALU;
				ctrl_o.reg_wen = 1'b1;
			end
			OP_OP: begin
				ctrl_o.alu_sel = alu_dec(funct3, alt);
				ctrl_o.wb_sel  = WB_ALU;
				ctrl_o.reg_wen = 1'b1;
			end
			OP_SYSTEM: begin
				if (funct3 inside {3'b001, 3'b010, 3'b011}) begin
					// ex takes the csr value as a and rs1 as b
					ctrl_o.alu_sel = csr_alu_op(funct3);
					ctrl_o.wb_sel  = WB_CSR;
					ctrl_o.reg_wen = 1'b1;
					ctrl_o.csr_we  = 1'b1;
				end
				is_mret_o = (inst_i == INST_MRET);
			end
			default: begin
				ctrl_o = '0; // unknown opcode
			end
		endcase
	end

endmodule

// ==== hdl/imm_gen.sv ====
module imm_gen (
	input  logic [24:0]      inst_i, // inst[31:7]
	input  rv_pkg::imm_sel_e imm_sel_i,
	output logic [31:0]      imm_o
);
	import rv_pkg::*;

	logic sign;

	assign sign = inst_i[24]; // inst[31]

	always_comb begin
		case (imm_sel_i)
			IMM_S: begin
				imm_o = {{20{sign}}, inst_i[24:18], inst_i[4:0]};
			end
			IMM_B: begin
				imm_o = {{19{sign}}, sign, inst_i[0], inst_i[23:18],
				         inst_i[4:1], 1'b0};
			end
			IMM_U: begin
				imm_o = {inst_i[24:5], 12'd0};
			end
			IMM_J: begin
				imm_o = {{11{sign}}, sign, inst_i[12:5], inst_i[13],
				         inst_i[23:14], 1'b0};
			end
			default: begin // I format
				imm_o = {{20{sign}}, inst_i[24:13]};
			end
		endcase
	end

endmodule

// ==== hdl/regfile.sv ====
module regfile (
	input  logic        clk_i,
	input  logic        rst_ni,
	input  rv_pkg::wb_t wb_i,
	input  logic [4:0]  rs1_addr_i,
	input  logic [4:0]  rs2_addr_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o
);

	logic [31:0] regs [32];
	logic        wr_act;
	logic        byp1;
	logic        byp2;

	assign wr_act = wb_i.wen && (wb_i.rd != 5'd0); // x0 never written
	assign byp1   = wr_act && (wb_i.rd == rs1_addr_i);
	assign byp2   = wr_act && (wb_i.rd == rs2_addr_i);

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_act) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// write-through so decode sees the value landing this cycle
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 :
	                    byp1 ? wb_i.data : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 :
	                    byp2 ? wb_i.data : regs[rs2_addr_i];

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011,
		OP_OP     = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10,
		ALU_ANDN   = 4'd11 // a & ~b, for csrrc
	} alu_op_e;

	typedef enum logic [2:0] {
		IMM_I = 3'd0,
		IMM_S = 3'd1,
		IMM_B = 3'd2,
		IMM_U = 3'd3,
		IMM_J = 3'd4
	} imm_sel_e;

	typedef enum logic [1:0] {
		WB_MEM = 2'd0,
		WB_ALU = 2'd1,
		WB_PC4 = 2'd2,
		WB_CSR = 2'd3
	} wb_sel_e;

	typedef struct packed {
		alu_op_e alu_sel;
		logic    a_sel;     // pc instead of rs1
		logic    b_sel;     // imm instead of rs2
		logic    mem_rw;    // store
		logic    mem_valid; // any load or store
		wb_sel_e wb_sel;
		logic    br_un;
		logic    reg_wen;
		logic    csr_we;
	} ctrl_t;

	typedef struct packed {
		logic        wen;
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_t;

	typedef struct packed {
		logic        we;
		logic [11:0] addr;
		logic [31:0] data;
	} csr_wr_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] pc4;
		logic [31:0] inst;
		logic [4:0]  rd;
		logic        hit;
		logic [31:0] csr_rdata;
		logic [11:0] csr_waddr;
		logic        is_mret;
		logic [31:0] pc_mret;
	} id_ex_t;

	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MIE     = 12'h304;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;
	localparam int MIE_MEIE     = 11;

	localparam logic [31:0] MCAUSE_EXT_INTR = 32'h8000_000B;
	localparam logic [31:0] INST_MRET       = 32'h3020_0073;

	// funct3 of the system group to the ALU op that forms the new csr value
	function automatic alu_op_e csr_alu_op(input logic [2:0] funct3);
		case (funct3)
			3'b001:  return ALU_PASS_B; // csrrw
			3'b010:  return ALU_OR;     // csrrs
			3'b011:  return ALU_ANDN;   // csrrc
			default: return ALU_ADD;
		endcase
	endfunction

endpackage
